// ==== design/line_pkg.sv ====
// shared widths and state types for the line rasterizer
// imported by the engine, the FIFO, the framebuffer and the top level

package line_pkg;

    // signed screen coordinate wide enough for off-screen endpoints
    localparam int cordw = 16;

    // colour index into a 16-entry palette
    localparam int cidxw = 4;

    // line engine states
    typedef enum logic [1:0] {
        idle,   // waiting for a command
        init,   // deltas and error term
        draw,   // one pixel per accepted step
        done    // one cycle before idle
    } draw_state_e;

    // framebuffer states
    typedef enum logic {
        clearing,  // sweeping every address to colour 0
        ready      // accepting pixel writes
    } clear_state_e;

endpackage

// ==== design/draw_line.sv ====
// Bresenham line engine that takes one command with two endpoints and a colour
// and streams the pixels of the line over valid/ready at one per cycle

`timescale 1ns/1ps

module draw_line (
    input  logic                              clk_pix,
    input  logic                              reset,
    input  logic                              cmd_valid,
    output logic                              cmd_ready,
    input  logic signed [line_pkg::cordw-1:0] x0,
    input  logic signed [line_pkg::cordw-1:0] y0,
    input  logic signed [line_pkg::cordw-1:0] x1,
    input  logic signed [line_pkg::cordw-1:0] y1,
    input  logic        [line_pkg::cidxw-1:0] cidx,
    output logic                              pix_valid,
    input  logic                              pix_ready,
    output logic signed [line_pkg::cordw-1:0] pix_x,
    output logic signed [line_pkg::cordw-1:0] pix_y,
    output logic        [line_pkg::cidxw-1:0] pix_cidx,
    output logic                              pix_last
);

    import line_pkg::*;

    // room for |dx| + |dy| and the doubled error without overflow
    localparam int ew = cordw + 3;

    draw_state_e state;

    logic signed [cordw-1:0] lx0, ly0, lx1, ly1;  // latched endpoints
    logic        [cidxw-1:0] col;

    logic signed [ew-1:0] diff_x, diff_y;
    logic signed [ew-1:0] abs_dx, neg_dy;
    logic signed [ew-1:0] dx, dy;    // dy kept negative
    logic signed [ew-1:0] err, e2, err_next;
    logic                 right, down;  // step directions
    logic signed [cordw-1:0] inc_x, inc_y;
    logic                 move_x, move_y;
    logic                 step;

    always_comb begin
        diff_x = {{3{lx1[cordw-1]}}, lx1} - {{3{lx0[cordw-1]}}, lx0};
        diff_y = {{3{ly1[cordw-1]}}, ly1} - {{3{ly0[cordw-1]}}, ly0};
        abs_dx = diff_x[ew-1] ? -diff_x : diff_x;
        neg_dy = diff_y[ew-1] ? diff_y : -diff_y;

        // decisions use the error before this step
        e2       = err <<< 1;
        move_x   = (e2 >= dy);
        move_y   = (e2 <= dx);
        err_next = err + (move_x ? dy : '0) + (move_y ? dx : '0);

        inc_x = {{(cordw-1){~right}}, 1'b1};  // +1 or -1
        inc_y = {{(cordw-1){~down}}, 1'b1};
    end

    assign pix_valid = (state == draw);
    assign pix_cidx  = col;
    assign pix_last  = pix_valid && (pix_x == lx1) && (pix_y == ly1);
    assign step      = pix_valid && pix_ready;

    // control
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state     <= idle;
            cmd_ready <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (cmd_valid && cmd_ready) begin
                        state     <= init;
                        cmd_ready <= 1'b0;
                    end else begin
                        cmd_ready <= 1'b1;
                    end
                end
                init: state <= draw;
                draw: if (step && pix_last) state <= done;
                done: begin
                    state     <= idle;
                    cmd_ready <= 1'b1;
                end
                default: state <= idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_pix) begin
        if (state == idle && cmd_valid && cmd_ready) begin
            lx0 <= x0;
            ly0 <= y0;
            lx1 <= x1;
            ly1 <= y1;
            col <= cidx;
        end

        if (state == init) begin
            pix_x <= lx0;  // first pixel is the start point
            pix_y <= ly0;
            dx    <= abs_dx;
            dy    <= neg_dy;
            err   <= abs_dx + neg_dy;
            right <= !diff_x[ew-1];
            down  <= !diff_y[ew-1];
        end else if (step && !pix_last) begin
            if (move_x) pix_x <= pix_x + inc_x;
            if (move_y) pix_y <= pix_y + inc_y;
            err <= err_next;
        end
        // coordinates and error hold while stalled
    end

endmodule

// ==== design/pixel_fifo.sv ====
// register-array FIFO for pixel writes between the line engine and the
// framebuffer with valid/ready on both sides; depth must be a power of two

`timescale 1ns/1ps

module pixel_fifo #(
    parameter int depth = 8
) (
    input  logic                              clk_pix,
    input  logic                              reset,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic signed [line_pkg::cordw-1:0] in_x,
    input  logic signed [line_pkg::cordw-1:0] in_y,
    input  logic        [line_pkg::cidxw-1:0] in_cidx,
    input  logic                              in_last,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic signed [line_pkg::cordw-1:0] out_x,
    output logic signed [line_pkg::cordw-1:0] out_y,
    output logic        [line_pkg::cidxw-1:0] out_cidx,
    output logic                              out_last
);

    import line_pkg::*;

    localparam int aw = $clog2(depth);
    localparam logic [aw:0] full_count = (aw+1)'(depth);

    logic signed [cordw-1:0] mem_x [depth];
    logic signed [cordw-1:0] mem_y [depth];
    logic        [cidxw-1:0] mem_c [depth];
    logic                    mem_l [depth];

    logic [aw-1:0] wr_ptr, rd_ptr;  // wrap naturally
    logic [aw:0]   count;
    logic          push, pop;

    assign in_ready  = (count != full_count);
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // head entry straight from the array
    assign out_x    = mem_x[rd_ptr];
    assign out_y    = mem_y[rd_ptr];
    assign out_cidx = mem_c[rd_ptr];
    assign out_last = mem_l[rd_ptr];

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (push) begin
            mem_x[wr_ptr] <= in_x;
            mem_y[wr_ptr] <= in_y;
            mem_c[wr_ptr] <= in_cidx;
            mem_l[wr_ptr] <= in_last;
        end
    end

endmodule

// ==== design/framebuffer.sv ====
// colour-index framebuffer in on-chip memory; clears itself to colour 0
// after reset, drops off-screen writes and has a one-cycle readback port

`timescale 1ns/1ps

module framebuffer #(
    parameter int width  = 32,
    parameter int height = 24
) (
    input  logic                              clk_pix,
    input  logic                              reset,
    input  logic                              wr_valid,
    output logic                              wr_ready,
    input  logic signed [line_pkg::cordw-1:0] wr_x,
    input  logic signed [line_pkg::cordw-1:0] wr_y,
    input  logic        [line_pkg::cidxw-1:0] wr_cidx,
    input  logic                              wr_last,
    input  logic signed [line_pkg::cordw-1:0] rd_x,
    input  logic signed [line_pkg::cordw-1:0] rd_y,
    output logic        [line_pkg::cidxw-1:0] rd_cidx,
    output logic                              done
);

    import line_pkg::*;

    localparam int depth = width * height;
    localparam int aw    = $clog2(depth);

    localparam logic signed [cordw-1:0] w_lim = cordw'(width);
    localparam logic signed [cordw-1:0] h_lim = cordw'(height);

    logic [cidxw-1:0] mem [depth];

    clear_state_e  state;
    logic [aw-1:0] clr_addr;
    logic          wr_fire;
    logic          wr_on, rd_on;
    logic [aw-1:0] wr_addr, rd_addr;

    function automatic logic on_screen(input logic signed [cordw-1:0] x,
                                       input logic signed [cordw-1:0] y);
        return !x[cordw-1] && !y[cordw-1] && (x < w_lim) && (y < h_lim);
    endfunction

    // row-major address that only matters for on-screen pixels
    function automatic logic [aw-1:0] pix_addr(input logic signed [cordw-1:0] x,
                                               input logic signed [cordw-1:0] y);
        return aw'(y) * aw'(width) + aw'(x);
    endfunction

    assign wr_ready = (state == ready);
    assign wr_fire  = wr_valid && wr_ready;
    assign wr_on    = on_screen(wr_x, wr_y);
    assign rd_on    = on_screen(rd_x, rd_y);
    assign wr_addr  = pix_addr(wr_x, wr_y);
    assign rd_addr  = pix_addr(rd_x, rd_y);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state    <= clearing;
            clr_addr <= '0;
            done     <= 1'b0;
        end else begin
            done <= wr_fire && wr_last;  // clipped or stored
            if (state == clearing) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == aw'(depth - 1)) state <= ready;
            end
        end
    end

    // a read on the edge of a write to the same pixel sees the old value
    always_ff @(posedge clk_pix) begin
        if (state == clearing) begin
            mem[clr_addr] <= '0;
        end else if (wr_fire && wr_on) begin
            mem[wr_addr] <= wr_cidx;
        end
        rd_cidx <= rd_on ? mem[rd_addr] : '0;
    end

endmodule

// ==== design/line_fb_top.sv ====
// line rasterizer top level chaining line engine, pixel FIFO and framebuffer
// plus a readback port and a done pulse at the end of each line

`timescale 1ns/1ps

module line_fb_top #(
    parameter int fb_width   = 32,
    parameter int fb_height  = 24,
    parameter int fifo_depth = 8
) (
    input  logic                              clk_pix,
    input  logic                              reset,
    input  logic                              cmd_valid,
    output logic                              cmd_ready,
    input  logic signed [line_pkg::cordw-1:0] x0,
    input  logic signed [line_pkg::cordw-1:0] y0,
    input  logic signed [line_pkg::cordw-1:0] x1,
    input  logic signed [line_pkg::cordw-1:0] y1,
    input  logic        [line_pkg::cidxw-1:0] cidx,
    input  logic signed [line_pkg::cordw-1:0] rd_x,
    input  logic signed [line_pkg::cordw-1:0] rd_y,
    output logic        [line_pkg::cidxw-1:0] rd_cidx,
    output logic                              done
);

    import line_pkg::*;

    // engine to FIFO
    logic                    pix_valid, pix_ready, pix_last;
    logic signed [cordw-1:0] pix_x, pix_y;
    logic        [cidxw-1:0] pix_cidx;

    // FIFO to framebuffer
    logic                    wr_valid, wr_ready, wr_last;
    logic signed [cordw-1:0] wr_x, wr_y;
    logic        [cidxw-1:0] wr_cidx;

    draw_line u_draw_line (
        .clk_pix,
        .reset,
        .cmd_valid,
        .cmd_ready,
        .x0,
        .y0,
        .x1,
        .y1,
        .cidx,
        .pix_valid,
        .pix_ready,
        .pix_x,
        .pix_y,
        .pix_cidx,
        .pix_last
    );

    pixel_fifo #(.depth(fifo_depth)) u_pixel_fifo (
        .clk_pix,
        .reset,
        .in_valid  (pix_valid),
        .in_ready  (pix_ready),
        .in_x      (pix_x),
        .in_y      (pix_y),
        .in_cidx   (pix_cidx),
        .in_last   (pix_last),
        .out_valid (wr_valid),
        .out_ready (wr_ready),
        .out_x     (wr_x),
        .out_y     (wr_y),
        .out_cidx  (wr_cidx),
        .out_last  (wr_last)
    );

    framebuffer #(
        .width  (fb_width),
        .height (fb_height)
    ) u_framebuffer (
        .clk_pix,
        .reset,
        .wr_valid,
        .wr_ready,  // low during the clear
        .wr_x,
        .wr_y,
        .wr_cidx,
        .wr_last,
        .rd_x,
        .rd_y,
        .rd_cidx,
        .done
    );

endmodule

// ==== verif/line_fb_checker.sv ====
// concurrent assertions on the handshakes, the done pulse and the pixel FIFO
// bound into the rasterizer top level at the end of this file

`timescale 1ns/1ps

module line_fb_checker #(
    parameter int fifo_depth = 8
) (
    input logic                              clk_pix,
    input logic                              reset,
    input logic                              cmd_ready,
    input line_pkg::draw_state_e             eng_state,
    input logic                              pix_valid,
    input logic                              pix_ready,
    input logic signed [line_pkg::cordw-1:0] pix_x,
    input logic signed [line_pkg::cordw-1:0] pix_y,
    input logic        [line_pkg::cidxw-1:0] pix_cidx,
    input logic                              pix_last,
    input logic                              wr_valid,
    input logic                              wr_ready,
    input logic signed [line_pkg::cordw-1:0] wr_x,
    input logic signed [line_pkg::cordw-1:0] wr_y,
    input logic        [line_pkg::cidxw-1:0] wr_cidx,
    input logic                              wr_last,
    input logic        [$clog2(fifo_depth):0] fifo_count,
    input logic                              done
);

    import line_pkg::*;

    // stalled pixel holds until taken
    a_pix_hold: assert property (@(posedge clk_pix) disable iff (reset)
        pix_valid && !pix_ready |=> pix_valid && $stable({pix_x, pix_y, pix_cidx, pix_last}))
        else $error("pixel stream dropped valid or changed data while stalled");

    a_wr_hold: assert property (@(posedge clk_pix) disable iff (reset)
        wr_valid && !wr_ready |=> wr_valid && $stable({wr_x, wr_y, wr_cidx, wr_last}))
        else $error("write stream dropped valid or changed data while stalled");

    a_done_pulse: assert property (@(posedge clk_pix) disable iff (reset)
        done |=> !done)
        else $error("done high for two cycles in a row");

    a_cmd_busy: assert property (@(posedge clk_pix) disable iff (reset)
        eng_state != idle |-> !cmd_ready)
        else $error("cmd_ready high while the line engine is busy");

    // a push into a full FIFO would lift the occupancy past the depth
    a_no_overflow: assert property (@(posedge clk_pix) disable iff (reset)
        fifo_count <= ($clog2(fifo_depth) + 1)'(fifo_depth))
        else $error("pixel FIFO written while full");

    // an empty FIFO only fills through a push
    a_no_underflow: assert property (@(posedge clk_pix) disable iff (reset)
        fifo_count == '0 && !(pix_valid && pix_ready) |=> fifo_count == '0)
        else $error("pixel FIFO read while empty");

endmodule

bind line_fb_top line_fb_checker #(.fifo_depth(fifo_depth)) u_checker (
    .*,
    .eng_state  (u_draw_line.state),
    .fifo_count (u_pixel_fifo.count)
);

// ==== verif/tb_line_fb.sv ====
// testbench for the line rasterizer that draws lines through the command port,
// mirrors them in a shadow frame and reads the whole screen back after each

`timescale 1ns/1ps

module tb_line_fb;

    import line_pkg::*;

    localparam int fb_w      = 32;
    localparam int fb_h      = 24;
    localparam int num_lines = 41;  // commands drawn below
    localparam int limit     = num_lines * (fb_w*fb_h*2 + 200) + 2 * (fb_w*fb_h + 16);

    logic                    clk_pix;
    logic                    reset;
    logic                    cmd_valid, cmd_ready;
    logic signed [cordw-1:0] x0, y0, x1, y1;
    logic        [cidxw-1:0] cidx;
    logic signed [cordw-1:0] rd_x, rd_y;
    logic        [cidxw-1:0] rd_cidx;
    logic                    done;

    int     shadow [fb_w*fb_h];  // expected colour per pixel
    integer seed = 76250;
    int     checks = 0;
    int     errors = 0;
    int     tests = 0;
    int     done_count = 0;
    event   cmp_start, cmp_done;

    line_fb_top #(.fb_width(fb_w), .fb_height(fb_h), .fifo_depth(8)) dut (.*);

    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;
    end

    always @(negedge clk_pix) begin
        if (done) done_count++;
    end

    function automatic int expected_at(input int x, input int y);
        if (x < 0 || y < 0 || x >= fb_w || y >= fb_h) return 0;  // off screen reads 0
        return shadow[y*fb_w + x];
    endfunction

    // reference Bresenham for all octants with clipped writes into the shadow frame
    function automatic void model_line(input int ax0, ay0, ax1, ay1, input int c);
        int dx, dy, sx, sy, err, e2, x, y;
        dx  = (ax1 > ax0) ? ax1 - ax0 : ax0 - ax1;
        dy  = (ay1 > ay0) ? ay0 - ay1 : ay1 - ay0;  // kept negative
        sx  = (ax1 >= ax0) ? 1 : -1;
        sy  = (ay1 >= ay0) ? 1 : -1;
        err = dx + dy;
        x   = ax0;
        y   = ay0;
        repeat (4096) begin
            if (x >= 0 && y >= 0 && x < fb_w && y < fb_h) shadow[y*fb_w + x] = c;
            if (x == ax1 && y == ay1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
    endfunction

    task automatic check_val(input int got, input int expv, input string what);
        checks++;
        if (got != expv) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %0d expected %0d", $time, what, got, expv);
        end
    endtask

    // compare process reading one ring beyond the screen; rd_cidx lags by one cycle
    initial begin
        int  px, py;
        bit  pend;
        rd_x = '0;
        rd_y = '0;
        forever begin
            @(cmp_start);
            pend = 1'b0;
            for (int y = -1; y <= fb_h; y++) begin
                for (int x = -1; x <= fb_w; x++) begin
                    @(negedge clk_pix);
                    if (pend) check_val(int'(rd_cidx), expected_at(px, py),
                                        $sformatf("pixel (%0d,%0d)", px, py));
                    rd_x = cordw'(x);
                    rd_y = cordw'(y);
                    px   = x;
                    py   = y;
                    pend = 1'b1;
                end
            end
            @(negedge clk_pix);
            check_val(int'(rd_cidx), expected_at(px, py), $sformatf("pixel (%0d,%0d)", px, py));
            -> cmp_done;
        end
    end

    task automatic apply_reset();
        reset     = 1'b1;
        cmd_valid = 1'b0;
        repeat (16) @(negedge clk_pix);
        reset = 1'b0;
        foreach (shadow[i]) shadow[i] = 0;  // frame clears itself
    endtask

    task automatic compare_frame();
        -> cmp_start;
        @(cmp_done);
    endtask

    // sends one command and waits for its done; wait_cyc counts cycles until cmd_ready
    task automatic send_line(input int ax0, ay0, ax1, ay1, input int c, output int wait_cyc);
        int start_done;
        start_done = done_count;
        wait_cyc   = 0;
        @(negedge clk_pix);
        x0        = cordw'(ax0);
        y0        = cordw'(ay0);
        x1        = cordw'(ax1);
        y1        = cordw'(ay1);
        cidx      = cidxw'(c);
        cmd_valid = 1'b1;
        while (!cmd_ready) begin
            @(negedge clk_pix);
            wait_cyc++;
        end
        @(negedge clk_pix);  // taken on the edge before
        cmd_valid = 1'b0;
        check_val(int'(cmd_ready), 0, "cmd_ready after accept");
        model_line(ax0, ay0, ax1, ay1, c);
        while (!done) @(negedge clk_pix);
        repeat (4) @(negedge clk_pix);
        check_val(done_count - start_done, 1, "done pulses per command");
    endtask

    task automatic draw_and_compare(input int ax0, ay0, ax1, ay1, input int c);
        int wc;
        send_line(ax0, ay0, ax1, ay1, c, wc);
        compare_frame();
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        if (errors == err_before) $display("test %s: ok", name);
        else $display("test %s: FAIL with %0d errors", name, errors - err_before);
    endtask

    initial begin
        int e0, wc;
        int rx0, ry0, rx1, ry1, rc;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        x0        = '0;
        y0        = '0;
        x1        = '0;
        y1        = '0;
        cidx      = '0;
        apply_reset();

        e0 = errors;
        repeat (fb_w*fb_h + 20) @(negedge clk_pix);  // past the clear sweep
        compare_frame();
        report("clear after reset", e0);

        e0 = errors;
        draw_and_compare(16, 12, 26, 15, 1);  // eight octants around the centre
        draw_and_compare(16, 12, 19, 22, 2);
        draw_and_compare(16, 12, 13, 22, 3);
        draw_and_compare(16, 12, 6, 15, 4);
        draw_and_compare(16, 12, 6, 9, 5);
        draw_and_compare(16, 12, 13, 2, 6);
        draw_and_compare(16, 12, 19, 2, 7);
        draw_and_compare(16, 12, 26, 9, 8);
        draw_and_compare(2, 20, 29, 20, 9);   // horizontal and vertical
        draw_and_compare(30, 1, 30, 22, 10);
        draw_and_compare(0, 0, 23, 23, 11);   // diagonals
        draw_and_compare(31, 0, 8, 23, 12);
        draw_and_compare(5, 5, 5, 5, 13);     // single points
        draw_and_compare(0, 23, 0, 23, 14);
        report("octants and single points", e0);

        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            rx0 = $unsigned($random(seed)) % fb_w;
            ry0 = $unsigned($random(seed)) % fb_h;
            rx1 = $unsigned($random(seed)) % fb_w;
            ry1 = $unsigned($random(seed)) % fb_h;
            rc  = $unsigned($random(seed)) % 16;
            draw_and_compare(rx0, ry0, rx1, ry1, rc);
        end
        report("random lines", e0);

        e0 = errors;
        draw_and_compare(-5, -3, 10, 8, 3);
        draw_and_compare(20, -10, 40, 30, 6);
        draw_and_compare(-8, 20, 40, 22, 9);
        draw_and_compare(29, 5, 35, 5, 12);   // x = 32 must not land on row 6
        draw_and_compare(-3, -3, -10, -1, 15);
        report("clipping", e0);

        e0 = errors;
        apply_reset();
        send_line(0, 0, 31, 20, 9, wc);       // queued behind the clear
        check_val(int'(wc <= 2), 1, "command accepted during clear");
        compare_frame();
        draw_and_compare(31, 0, 0, 23, 4);
        report("handshake and back-pressure", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) $display("sim passed");
        else $display("sim failed");
        $finish;
    end

    // watchdog
    initial begin
        repeat (limit) @(posedge clk_pix);
        $display("timeout: the tests did not finish within %0d clock cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== flist.f ====
design/line_pkg.sv
design/draw_line.sv
design/pixel_fifo.sv
design/framebuffer.sv
design/line_fb_top.sv
verif/line_fb_checker.sv
verif/tb_line_fb.sv

// ==== Makefile ====
TOP = tb_line_fb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ) -f flist.f

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf $(OBJ) sim.log
